// ==== files.f ====
verilog/dsp_data_pkg.sv
verilog/dsp_ctrl_pkg.sv
verilog/dsp_apb_regs.sv
verilog/shot_sequencer.sv
verilog/baseband_select.sv
verilog/readout_integrator.sv
verilog/dsp_top.sv
dv/dsp_assertions.sv
dv/dsp_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= dsp_tb
FILELIST ?= files.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
PASS_MSG ?= Regression passed
FAIL_MSG ?= Regression failed
VFLAGS ?=

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) --binary --timing --assert -f $(FILELIST) --top-module $(TOP) \
		--Mdir $(BUILD_DIR) $(VFLAGS)

run: build
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG) || { echo "simulation ended early"; exit 1; }

lint:
	$(VERILATOR) --lint-only -Wall --timing -f $(FILELIST) --top-module $(TOP) $(VFLAGS)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== dv/dsp_tb.sv ====
/*
 * testbench for dsp_top
 * clock, reset, apb driver, processor bank model, lfsr
 * directed tests for registers, shots, integration, undersampling, pointer lock
 * watchdog sized from the test budgets
 */
`timescale 1ns/1ps

module dsp_tb;

	localparam logic [31:0] lfsr_seed = 32'h8f7d;
	// x^32 + x^22 + x^2 + x + 1
	localparam logic [31:0] lfsr_taps = 32'h8020_0003;
	localparam int clk_period = 10;
	// cycle budgets per test, reset included in the first
	localparam int budget_regs = 80;
	localparam int budget_shots = 200;
	localparam int budget_unlimited = 300;
	localparam int budget_integ = 100;
	localparam int budget_under = 100;
	localparam int budget_lock = 300;
	localparam int budget_cycles = budget_regs + budget_shots + budget_unlimited
		+ budget_integ + budget_under + budget_lock;

	logic dspif;
	logic rst;
	dsp_ctrl_pkg::apb_req_t apb;
	logic [dsp_ctrl_pkg::apb_data_width-1:0] prdata;
	logic pready;
	logic pslverr;
	logic [dsp_data_pkg::n_chan-1:0][dsp_data_pkg::adc_width-1:0] adc;
	dsp_data_pkg::dac_word_t [dsp_data_pkg::n_dac-1:0] dac;
	logic [dsp_ctrl_pkg::n_proc-1:0] proc_done;
	logic [dsp_ctrl_pkg::n_proc-1:0] proc_idle;
	logic [dsp_data_pkg::n_chan-1:0] gate;
	logic [dsp_ctrl_pkg::n_proc-1:0] proc_reset;
	dsp_data_pkg::acc_write_t [dsp_data_pkg::n_chan-1:0] acc_wr;

	logic [31:0] lfsr = lfsr_seed;
	// expected write pointer, same on both channels
	logic [dsp_data_pkg::acc_addr_width-1:0] exp_ptr;
	int shot_falls = 0;

	dsp_top u_dut (
		.dspif(dspif),
		.rst(rst),
		.apb(apb),
		.prdata(prdata),
		.pready(pready),
		.pslverr(pslverr),
		.adc(adc),
		.dac(dac),
		.proc_done(proc_done),
		.proc_idle(proc_idle),
		.gate(gate),
		.proc_reset(proc_reset),
		.acc_wr(acc_wr)
	);

	initial begin
		dspif = 1'b0;
		forever #(clk_period / 2) dspif = ~dspif;
	end

	initial begin : watchdog
		#(budget_cycles * clk_period);
		$display("Timeout: tests did not finish within %0d cycles", budget_cycles);
		$display("Regression failed");
		$fatal(1);
	end

	// every shot starts with a fall of proc_reset
	always @(negedge proc_reset[0]) shot_falls++;

	// galois lfsr, one step per bit taken
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] val;
		val = '0;
		for (int i = 0; i < n; i++) begin
			val = {val[30:0], lfsr[0]};
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ lfsr_taps) : (lfsr >> 1);
		end
		return val;
	endfunction

	// accaddr register view, one byte per channel
	function automatic logic [31:0] ptr_word(input logic [dsp_data_pkg::acc_addr_width-1:0] p);
		return {16'h0, 8'(p), 8'(p)};
	endfunction

	task automatic report_mismatch(input string name, input logic [31:0] exp,
		input logic [31:0] got);
		$display("Fail at %0t: %s expected 0x%0h, got 0x%0h", $time, name, exp, got);
		$display("Regression failed");
		$fatal(1);
	endtask

	task automatic report_failure(input string msg);
		$display("Error at %0t: %s", $time, msg);
		$display("Regression failed");
		$fatal(1);
	endtask

	task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] got);
		assert (got === exp) else report_mismatch(name, exp, got);
	endtask

	// pulse processor bank: runs 3 to 10 cycles, done, idle back 2 cycles later
	initial begin : proc_model
		int run_left;
		int idle_left;
		proc_done = '0;
		proc_idle = '1;
		run_left = -1;
		idle_left = 0;
		forever begin
			@(negedge dspif);
			if (idle_left > 0) begin
				idle_left--;
				if (idle_left == 0) begin
					proc_idle = '1;
				end
			end
			if (proc_reset[0]) begin
				proc_done = '0;
				run_left = -1;
			end else if (run_left < 0) begin
				run_left = 3 + int'(rand_bits(3));
			end else if (run_left > 0) begin
				run_left--;
				if (run_left == 0) begin
					proc_done = '1;
					proc_idle = '0;
					idle_left = 2;
				end
			end
		end
	end

	// one apb3 transfer, setup then access, outputs sampled mid access phase
	task automatic apb_access(input logic wr, input logic [7:0] addr, input logic [31:0] wdata,
		output logic [31:0] rdata, output logic err);
		@(negedge dspif);
		apb.psel = 1'b1;
		apb.penable = 1'b0;
		apb.pwrite = wr;
		apb.paddr = addr;
		apb.pwdata = wdata;
		@(negedge dspif);
		apb.penable = 1'b1;
		#1;
		rdata = prdata;
		err = pslverr;
		@(negedge dspif);
		apb.psel = 1'b0;
		apb.penable = 1'b0;
		apb.pwrite = 1'b0;
	endtask

	task automatic write_reg(input logic [7:0] addr, input logic [31:0] data);
		logic [31:0] rdata;
		logic err;
		apb_access(1'b1, addr, data, rdata, err);
		check_val("pslverr", 1'b0, err);
	endtask

	task automatic read_check(input string name, input logic [7:0] addr, input logic [31:0] exp);
		logic [31:0] rdata;
		logic err;
		apb_access(1'b0, addr, '0, rdata, err);
		check_val("pslverr", 1'b0, err);
		check_val(name, exp, rdata);
	endtask

	// poll status until done, bounded
	task automatic wait_seq_done(input int max_polls);
		logic [31:0] rdata;
		logic err;
		int polls;
		rdata = '0;
		polls = 0;
		while (!rdata[0] && polls < max_polls) begin
			apb_access(1'b0, dsp_ctrl_pkg::reg_status, '0, rdata, err);
			polls++;
		end
		assert (rdata[0]) else report_failure("sequencer never reported done");
	endtask

	// gate both channels for n cycles, expect a single dump write
	task automatic run_burst(input int n, input logic [31:0] exp0, input logic [31:0] exp1);
		int waited;
		@(negedge dspif);
		gate = '1;
		repeat (n) @(negedge dspif);
		gate = '0;
		waited = 0;
		while (!acc_wr[0].we && waited < 10) begin
			@(negedge dspif);
			waited++;
		end
		assert (acc_wr[0].we) else report_failure("no accumulator write after the gate fell");
		check_val("acc_wr[1].we", 1'b1, acc_wr[1].we);
		check_val("acc_wr[0].addr", exp_ptr, acc_wr[0].addr);
		check_val("acc_wr[1].addr", exp_ptr, acc_wr[1].addr);
		check_val("acc_wr[0].sum", exp0, acc_wr[0].sum);
		check_val("acc_wr[1].sum", exp1, acc_wr[1].sum);
		@(negedge dspif);
		// one write per burst
		check_val("acc_wr[0].we", 1'b0, acc_wr[0].we);
		check_val("acc_wr[1].we", 1'b0, acc_wr[1].we);
		// pointer locks at all ones
		if (exp_ptr != '1) begin
			exp_ptr++;
		end
	endtask

	// constant random adc words over one burst
	task automatic adc_burst(input int n);
		@(negedge dspif);
		adc[0] = {rand_bits(32), rand_bits(32)};
		adc[1] = {rand_bits(32), rand_bits(32)};
		run_burst(n, int'($signed(adc[0][15:0])) * n, int'($signed(adc[1][15:0])) * n);
	endtask

	task automatic test_register_access();
		logic [31:0] val;
		logic [31:0] rdata;
		logic err;
		read_check("status", dsp_ctrl_pkg::reg_status, 32'h1);
		read_check("shotcnt", dsp_ctrl_pkg::reg_shotcnt, 32'h0);
		val = rand_bits(32);
		write_reg(dsp_ctrl_pkg::reg_nshot, val);
		read_check("nshot", dsp_ctrl_pkg::reg_nshot, val);
		val = rand_bits(4);
		write_reg(dsp_ctrl_pkg::reg_mixsel, val);
		read_check("mixsel", dsp_ctrl_pkg::reg_mixsel, val);
		// read only and unmapped both answer with an error
		apb_access(1'b1, dsp_ctrl_pkg::reg_status, 32'h3, rdata, err);
		check_val("pslverr", 1'b1, err);
		apb_access(1'b0, 8'h20, '0, rdata, err);
		check_val("pslverr", 1'b1, err);
	endtask

	task automatic test_shot_count();
		int base;
		base = shot_falls;
		write_reg(dsp_ctrl_pkg::reg_nshot, 32'd3);
		write_reg(dsp_ctrl_pkg::reg_ctrl, 32'h1);
		// busy, not done
		read_check("status", dsp_ctrl_pkg::reg_status, 32'h2);
		wait_seq_done(40);
		check_val("proc_reset falls", 32'd3, shot_falls - base);
		// count holds shots finished before the last advance
		read_check("shotcnt", dsp_ctrl_pkg::reg_shotcnt, 32'd2);
		read_check("status", dsp_ctrl_pkg::reg_status, 32'h1);
	endtask

	task automatic test_unlimited_run();
		int base;
		int waited;
		base = shot_falls;
		write_reg(dsp_ctrl_pkg::reg_nshot, 32'd0);
		write_reg(dsp_ctrl_pkg::reg_ctrl, 32'h1);
		waited = 0;
		while (shot_falls - base < 6 && waited < 250) begin
			@(negedge dspif);
			waited++;
		end
		assert (shot_falls - base > 5) else report_failure("unlimited run stopped before six shots");
		read_check("status", dsp_ctrl_pkg::reg_status, 32'h2);
		@(negedge dspif);
		rst = 1'b1;
		repeat (2) @(negedge dspif);
		rst = 1'b0;
		read_check("status", dsp_ctrl_pkg::reg_status, 32'h1);
		read_check("shotcnt", dsp_ctrl_pkg::reg_shotcnt, 32'h0);
	endtask

	task automatic test_integration();
		write_reg(dsp_ctrl_pkg::reg_mixsel, 32'h0);
		repeat (3) begin
			adc_burst(1 + int'(rand_bits(3)));
			read_check("accaddr", dsp_ctrl_pkg::reg_accaddr, ptr_word(exp_ptr));
		end
	endtask

	task automatic test_undersample();
		dsp_ctrl_pkg::mixsel_t sel;
		@(negedge dspif);
		for (int w = 0; w < dsp_data_pkg::n_dac; w++) begin
			for (int k = 0; k < dsp_data_pkg::dac_samples; k++) begin
				dac[w].samp[k] = 16'(rand_bits(16));
			end
		end
		// channel 0 sees dac sample 0, channel 1 dac sample 4
		for (int w = 0; w < dsp_data_pkg::n_dac; w++) begin
			sel = (w == 0) ? dsp_ctrl_pkg::sel_dac_a : dsp_ctrl_pkg::sel_dac_b;
			write_reg(dsp_ctrl_pkg::reg_mixsel, {28'h0, sel, sel});
			run_burst(4, int'($signed(dac[w].samp[0])) * 4, int'($signed(dac[w].samp[4])) * 4);
		end
		write_reg(dsp_ctrl_pkg::reg_mixsel, {28'h0, dsp_ctrl_pkg::sel_zero, dsp_ctrl_pkg::sel_zero});
		run_burst(4, 32'h0, 32'h0);
		read_check("accaddr", dsp_ctrl_pkg::reg_accaddr, ptr_word(exp_ptr));
	endtask

	task automatic test_pointer_lock();
		write_reg(dsp_ctrl_pkg::reg_mixsel, 32'h0);
		repeat (20) adc_burst(2);
		// both pointers stuck at the last address
		read_check("accaddr", dsp_ctrl_pkg::reg_accaddr, 32'h0000_0f0f);
		write_reg(dsp_ctrl_pkg::reg_ctrl, 32'h2);
		read_check("accaddr", dsp_ctrl_pkg::reg_accaddr, 32'h0);
		write_reg(dsp_ctrl_pkg::reg_ctrl, 32'h0);
		exp_ptr = '0;
	endtask

	initial begin : main
		rst = 1'b1;
		apb = '0;
		adc = '0;
		dac = '0;
		gate = '0;
		exp_ptr = '0;
		repeat (2) @(negedge dspif);
		rst = 1'b0;
		test_register_access();
		test_shot_count();
		test_unlimited_run();
		test_integration();
		test_undersample();
		test_pointer_lock();
		$display("Regression passed");
		$finish;
	end

endmodule

// ==== dv/dsp_assertions.sv ====
/*
 * concurrent checks on the dsp block
 * apb handshake and sequencer reset, bound into dsp_top
 */
`timescale 1ns/1ps

module dsp_assertions (
	input logic dspif,
	input logic rst,
	input logic psel,
	input logic penable,
	input logic pready,
	input logic done,
	input logic [dsp_ctrl_pkg::n_proc-1:0] proc_reset
);

	// slave never stretches an access
	pready_high: assert property (@(posedge dspif) disable iff (rst) pready)
		else $error("pready went low");

	// an access phase is always followed by idle or setup
	no_back_to_back: assert property (@(posedge dspif) disable iff (rst)
		(psel && penable) |=> !(psel && penable))
		else $error("apb access phase held for two cycles");

	// processors stay in reset while the sequencer reports done
	reset_when_done: assert property (@(posedge dspif) disable iff (rst)
		done |-> &proc_reset)
		else $error("proc_reset low while status done is high");

endmodule

bind dsp_top dsp_assertions u_assertions (
	.dspif(dspif),
	.rst(rst),
	.psel(apb.psel),
	.penable(apb.penable),
	.pready(pready),
	.done(seq_status.done),
	.proc_reset(proc_reset)
);

// ==== verilog/dsp_top.sv ====
/*
 * dsp block top level
 * apb registers, shot sequencer, baseband select
 * one readout integrator per channel
 */
`timescale 1ns/1ps

module dsp_top (
	input logic dspif,
	input logic rst,
	input dsp_ctrl_pkg::apb_req_t apb,
	output logic [dsp_ctrl_pkg::apb_data_width-1:0] prdata,
	output logic pready,
	output logic pslverr,
	input logic [dsp_data_pkg::n_chan-1:0][dsp_data_pkg::adc_width-1:0] adc,
	input dsp_data_pkg::dac_word_t [dsp_data_pkg::n_dac-1:0] dac,
	input logic [dsp_ctrl_pkg::n_proc-1:0] proc_done,
	input logic [dsp_ctrl_pkg::n_proc-1:0] proc_idle,
	input logic [dsp_data_pkg::n_chan-1:0] gate,
	output logic [dsp_ctrl_pkg::n_proc-1:0] proc_reset,
	output dsp_data_pkg::acc_write_t [dsp_data_pkg::n_chan-1:0] acc_wr
);

	dsp_ctrl_pkg::seq_status_t seq_status;
	dsp_ctrl_pkg::mixsel_t [dsp_data_pkg::n_chan-1:0] mixsel;
	logic [dsp_data_pkg::n_chan-1:0][dsp_data_pkg::acc_addr_width-1:0] acc_addr;
	logic [dsp_ctrl_pkg::apb_data_width-1:0] nshot;
	logic start;
	logic resetacc;
	logic signed [dsp_data_pkg::n_chan-1:0][dsp_data_pkg::sample_width-1:0] sample;
	logic [dsp_data_pkg::n_chan-1:0] gate_d;

	dsp_apb_regs u_regs (
		.dspif(dspif),
		.rst(rst),
		.apb(apb),
		.prdata(prdata),
		.pready(pready),
		.pslverr(pslverr),
		.status(seq_status),
		.acc_addr(acc_addr),
		.start(start),
		.resetacc(resetacc),
		.nshot(nshot),
		.mixsel(mixsel)
	);

	shot_sequencer u_seq (
		.dspif(dspif),
		.rst(rst),
		.start(start),
		.nshot(nshot),
		.proc_done(proc_done),
		.proc_idle(proc_idle),
		.proc_reset(proc_reset),
		.status(seq_status)
	);

	// two-cycle source select, gate kept aligned
	baseband_select u_bb (
		.dspif(dspif),
		.rst(rst),
		.adc(adc),
		.dac(dac),
		.mixsel(mixsel),
		.gate(gate),
		.sample(sample),
		.gate_d(gate_d)
	);

	for (genvar c = 0; c < dsp_data_pkg::n_chan; c++) begin : g_chan
		readout_integrator u_int (
			.dspif(dspif),
			.rst(rst),
			.resetacc(resetacc),
			.sample(sample[c]),
			.gate(gate_d[c]),
			.acc_wr(acc_wr[c]),
			.acc_addr(acc_addr[c])
		);
	end

endmodule

// ==== verilog/readout_integrator.sv ====
/*
 * gated integrate and dump for one readout channel
 * sum written on gate fall, write pointer locks at the last address
 */
`timescale 1ns/1ps

module readout_integrator (
	input logic dspif,
	input logic rst,
	input logic resetacc,
	input logic signed [dsp_data_pkg::sample_width-1:0] sample,
	input logic gate,
	output dsp_data_pkg::acc_write_t acc_wr,
	output logic [dsp_data_pkg::acc_addr_width-1:0] acc_addr
);

	localparam int ext_bits = dsp_data_pkg::acc_width - dsp_data_pkg::sample_width;

	logic signed [dsp_data_pkg::acc_width-1:0] sample_ext;
	logic signed [dsp_data_pkg::acc_width-1:0] acc;
	logic signed [dsp_data_pkg::acc_width-1:0] sum_q;
	logic [dsp_data_pkg::acc_addr_width-1:0] ptr;
	logic [dsp_data_pkg::acc_addr_width-1:0] addr_q;
	logic gate_q;
	logic gate_fall;
	logic we_q;
	logic ptr_last;

	// sign extend to the accumulator width
	assign sample_ext = {{ext_bits{sample[dsp_data_pkg::sample_width-1]}}, sample};
	assign gate_fall = gate_q & ~gate;
	// pointer all ones, stop here
	assign ptr_last = &ptr;
	assign acc_addr = ptr;

	always_ff @(posedge dspif) begin
		if (rst) begin
			gate_q <= 1'b0;
			we_q <= 1'b0;
			ptr <= '0;
		end else begin
			gate_q <= gate;
			// dump one cycle after the fall
			we_q <= gate_fall;
			if (resetacc) begin
				ptr <= '0;
			end else if (we_q & ~ptr_last) begin
				ptr <= ptr + 1'b1;
			end
		end
	end

	// first gated cycle loads, later ones add
	always_ff @(posedge dspif) begin
		if (gate) begin
			acc <= gate_q ? acc + sample_ext : sample_ext;
		end
		if (gate_fall) begin
			sum_q <= acc;
			addr_q <= ptr;
		end
	end

	assign acc_wr = '{we: we_q, addr: addr_q, sum: sum_q};

endmodule

// ==== verilog/baseband_select.sv ====
/*
 * baseband source select for the readout channels
 * input registers, dac undersampling, per-channel source mux
 * gate delayed to stay aligned with the sample
 */
`timescale 1ns/1ps

module baseband_select (
	input logic dspif,
	input logic rst,
	input logic [dsp_data_pkg::n_chan-1:0][dsp_data_pkg::adc_width-1:0] adc,
	input dsp_data_pkg::dac_word_t [dsp_data_pkg::n_dac-1:0] dac,
	input dsp_ctrl_pkg::mixsel_t [dsp_data_pkg::n_chan-1:0] mixsel,
	input logic [dsp_data_pkg::n_chan-1:0] gate,
	output logic signed [dsp_data_pkg::n_chan-1:0][dsp_data_pkg::sample_width-1:0] sample,
	output logic [dsp_data_pkg::n_chan-1:0] gate_d
);

	logic [dsp_data_pkg::n_chan-1:0][dsp_data_pkg::adc_width-1:0] adc_q;
	// undersampled dac words, same layout as an adc word
	logic [dsp_data_pkg::n_dac-1:0][dsp_data_pkg::adc_samples-1:0]
		[dsp_data_pkg::sample_width-1:0] us_q;
	logic [dsp_data_pkg::n_chan-1:0] gate_q;

	// stage 1, register adc and keep every fourth dac sample
	always_ff @(posedge dspif) begin
		adc_q <= adc;
		for (int w = 0; w < dsp_data_pkg::n_dac; w++) begin
			for (int j = 0; j < dsp_data_pkg::adc_samples; j++) begin
				us_q[w][j] <= dac[w].samp[j*dsp_data_pkg::us_step];
			end
		end
	end

	// stage 2, low sample of the chosen word
	// channel c takes undersampled sample c, i.e. dac sample 4c
	always_ff @(posedge dspif) begin
		for (int c = 0; c < dsp_data_pkg::n_chan; c++) begin
			case (mixsel[c])
				dsp_ctrl_pkg::sel_adc: sample[c] <= adc_q[c][dsp_data_pkg::sample_width-1:0];
				dsp_ctrl_pkg::sel_dac_a: sample[c] <= us_q[0][c];
				dsp_ctrl_pkg::sel_dac_b: sample[c] <= us_q[1][c];
				dsp_ctrl_pkg::sel_zero: sample[c] <= '0;
			endcase
		end
	end

	// gate through the same two stages
	always_ff @(posedge dspif) begin
		if (rst) begin
			gate_q <= '0;
			gate_d <= '0;
		end else begin
			gate_q <= gate;
			gate_d <= gate_q;
		end
	end

endmodule

// ==== verilog/shot_sequencer.sv ====
/*
 * multi-shot sequencer
 * runs the processor bank nshot times, processors held in reset between shots
 * nshot of zero repeats until reset
 */
`timescale 1ns/1ps

module shot_sequencer (
	input logic dspif,
	input logic rst,
	input logic start,
	input logic [dsp_ctrl_pkg::apb_data_width-1:0] nshot,
	input logic [dsp_ctrl_pkg::n_proc-1:0] proc_done,
	input logic [dsp_ctrl_pkg::n_proc-1:0] proc_idle,
	output logic [dsp_ctrl_pkg::n_proc-1:0] proc_reset,
	output dsp_ctrl_pkg::seq_status_t status
);

	typedef enum logic [2:0] {
		st_idle,
		st_start,
		st_run,
		st_wait_idle,
		st_check,
		st_advance,
		st_done
	} state_t;

	state_t state;
	state_t state_nxt;
	logic [dsp_ctrl_pkg::apb_data_width-1:0] nshot_q;
	logic [dsp_ctrl_pkg::apb_data_width-1:0] shot_cnt;
	logic [dsp_ctrl_pkg::apb_data_width-1:0] next_cnt;
	logic more;
	logic all_done;
	logic all_idle;
	logic done_q;
	logic busy_q;

	always_comb begin
		state_nxt = state;
		case (state)
			st_idle: if (start) state_nxt = st_start;
			st_start: state_nxt = st_run;
			// all processors finished their program
			st_run: if (all_done) state_nxt = st_wait_idle;
			// wait for the element pipelines to drain
			st_wait_idle: if (all_idle) state_nxt = st_check;
			st_check: state_nxt = more ? st_advance : st_done;
			st_advance: state_nxt = st_start;
			st_done: state_nxt = st_idle;
			default: state_nxt = st_idle;
		endcase
	end

	always_ff @(posedge dspif) begin
		if (rst) begin
			state <= st_idle;
			nshot_q <= '0;
			shot_cnt <= '0;
			next_cnt <= '0;
			more <= 1'b0;
			all_done <= 1'b0;
			all_idle <= 1'b0;
			proc_reset <= '1;
			done_q <= 1'b1;
			busy_q <= 1'b0;
		end else begin
			state <= state_nxt;
			// processor flags, registered before use
			all_done <= &proc_done;
			all_idle <= &proc_idle;
			// nshot only follows the register while idle
			if (state == st_idle) begin
				nshot_q <= nshot;
			end
			// count one ahead, decision one more cycle later
			next_cnt <= shot_cnt + 1'b1;
			more <= (nshot_q == '0) | (next_cnt != nshot_q);
			if (state == st_idle && start) begin
				shot_cnt <= '0;
			end else if (state == st_advance) begin
				shot_cnt <= next_cnt;
			end
			// outputs follow the state they belong to
			proc_reset <= {dsp_ctrl_pkg::n_proc{~(state_nxt == st_start || state_nxt == st_run)}};
			done_q <= (state_nxt == st_idle) || (state_nxt == st_done);
			busy_q <= state_nxt != st_idle;
		end
	end

	assign status = '{done: done_q, busy: busy_q, shot_cnt: shot_cnt};

endmodule

// ==== verilog/dsp_apb_regs.sv ====
/*
 * apb3 slave for the dsp block
 * control, nshot and source select registers
 * start strobe generation, status and pointer readback
 */
`timescale 1ns/1ps

module dsp_apb_regs (
	input logic dspif,
	input logic rst,
	input dsp_ctrl_pkg::apb_req_t apb,
	output logic [dsp_ctrl_pkg::apb_data_width-1:0] prdata,
	output logic pready,
	output logic pslverr,
	input dsp_ctrl_pkg::seq_status_t status,
	input logic [dsp_data_pkg::n_chan-1:0][dsp_data_pkg::acc_addr_width-1:0] acc_addr,
	output logic start,
	output logic resetacc,
	output logic [dsp_ctrl_pkg::apb_data_width-1:0] nshot,
	output dsp_ctrl_pkg::mixsel_t [dsp_data_pkg::n_chan-1:0] mixsel
);

	logic access;
	logic wr_en;
	logic mapped;
	logic read_only;
	logic start_wr;
	logic [dsp_ctrl_pkg::apb_data_width-1:0] rdata;
	logic [dsp_ctrl_pkg::apb_data_width-1:0] accaddr_word;

	// access phase is psel with penable
	assign access = apb.psel & apb.penable;
	assign wr_en = access & apb.pwrite;
	// no wait states
	assign pready = 1'b1;

	// one byte per channel pointer
	always_comb begin
		accaddr_word = '0;
		for (int i = 0; i < dsp_data_pkg::n_chan; i++) begin
			accaddr_word[8*i +: 8] = 8'(acc_addr[i]);
		end
	end

	// address decode and read mux
	always_comb begin
		mapped = 1'b1;
		read_only = 1'b0;
		rdata = '0;
		case (apb.paddr)
			dsp_ctrl_pkg::reg_ctrl: rdata[dsp_ctrl_pkg::ctrl_resetacc_bit] = resetacc;
			dsp_ctrl_pkg::reg_nshot: rdata = nshot;
			dsp_ctrl_pkg::reg_mixsel: rdata[$bits(mixsel)-1:0] = mixsel;
			dsp_ctrl_pkg::reg_status: begin
				read_only = 1'b1;
				rdata[0] = status.done;
				rdata[1] = status.busy;
			end
			dsp_ctrl_pkg::reg_shotcnt: begin
				read_only = 1'b1;
				rdata = status.shot_cnt;
			end
			dsp_ctrl_pkg::reg_accaddr: begin
				read_only = 1'b1;
				rdata = accaddr_word;
			end
			default: mapped = 1'b0;
		endcase
	end

	// data only in a read access phase
	assign prdata = (access & ~apb.pwrite) ? rdata : '0;
	// unmapped, or write to a status register
	assign pslverr = access & (~mapped | (apb.pwrite & read_only));

	always_ff @(posedge dspif) begin
		if (rst) begin
			start_wr <= 1'b0;
			start <= 1'b0;
			resetacc <= 1'b0;
			nshot <= '0;
			mixsel <= '0;
		end else begin
			// write strobe captured at the access edge, start one cycle later
			start_wr <= wr_en && (apb.paddr == dsp_ctrl_pkg::reg_ctrl)
				&& apb.pwdata[dsp_ctrl_pkg::ctrl_start_bit];
			start <= start_wr;
			if (wr_en) begin
				case (apb.paddr)
					dsp_ctrl_pkg::reg_ctrl: resetacc <= apb.pwdata[dsp_ctrl_pkg::ctrl_resetacc_bit];
					dsp_ctrl_pkg::reg_nshot: nshot <= apb.pwdata;
					dsp_ctrl_pkg::reg_mixsel: mixsel <= apb.pwdata[$bits(mixsel)-1:0];
					default: ;
				endcase
			end
		end
	end

endmodule

// ==== verilog/dsp_ctrl_pkg.sv ====
/*
 * control-side definitions
 * processor count, apb widths and register map
 * ctrl bit positions and source select codes
 * apb request struct, sequencer status struct
 */
package dsp_ctrl_pkg;

	// size of the external pulse processor bank
	localparam int n_proc = 4;

	localparam int apb_addr_width = 8;
	localparam int apb_data_width = 32;

	// register map
	localparam logic [apb_addr_width-1:0] reg_ctrl = 8'h00;
	localparam logic [apb_addr_width-1:0] reg_nshot = 8'h04;
	localparam logic [apb_addr_width-1:0] reg_mixsel = 8'h08;
	localparam logic [apb_addr_width-1:0] reg_status = 8'h0C;
	localparam logic [apb_addr_width-1:0] reg_shotcnt = 8'h10;
	localparam logic [apb_addr_width-1:0] reg_accaddr = 8'h14;

	// ctrl register bits
	localparam int ctrl_start_bit = 0;
	localparam int ctrl_resetacc_bit = 1;

	// baseband source per channel
	typedef logic [1:0] mixsel_t;
	localparam mixsel_t sel_adc = 2'd0;
	localparam mixsel_t sel_dac_a = 2'd1;
	localparam mixsel_t sel_dac_b = 2'd2;
	localparam mixsel_t sel_zero = 2'd3;

	typedef struct packed {
		logic psel;
		logic penable;
		logic pwrite;
		logic [apb_addr_width-1:0] paddr;
		logic [apb_data_width-1:0] pwdata;
	} apb_req_t;

	typedef struct packed {
		logic done;
		logic busy;
		logic [apb_data_width-1:0] shot_cnt;
	} seq_status_t;

endpackage

// ==== verilog/dsp_data_pkg.sv ====
/*
 * data-path definitions for the baseband and integrator blocks
 * sample, word and accumulator widths, channel and dac word counts
 * dac word union (flat word or per-sample view)
 * accumulation buffer write struct
 */
package dsp_data_pkg;

	// one adc word carries four 16-bit samples
	localparam int adc_width = 64;
	localparam int sample_width = 16;
	localparam int adc_samples = adc_width / sample_width;

	// one dac word carries sixteen samples
	localparam int dac_samples = 16;
	localparam int dac_width = dac_samples * sample_width;
	// dac word A and dac word B
	localparam int n_dac = 2;
	// undersampling keeps every fourth dac sample
	localparam int us_step = dac_samples / adc_samples;

	// readout channels
	localparam int n_chan = 2;

	// integrated sum
	localparam int acc_width = 32;
	// small buffer, fills after 16 dumps
	localparam int acc_addr_width = 4;

	// flat on the port, per sample for the undersampler
	typedef union packed {
		logic [dac_width-1:0] flat;
		logic signed [dac_samples-1:0][sample_width-1:0] samp;
	} dac_word_t;

	// one write into the accumulation buffer
	typedef struct packed {
		logic we;
		logic [acc_addr_width-1:0] addr;
		logic signed [acc_width-1:0] sum;
	} acc_write_t;

endpackage
